/* verilog/ahb_pkg.sv */
package ahb_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // 64 words of memory, byte address taken modulo 256
    localparam int MEM_AW = 6;

    // 16-byte wrap boundary of a WRAP4 burst of words
    localparam logic [ADDR_W-1:0] WRAP4_MASK = 32'hFFFF_FFF0;

    localparam int BEATS4 = 4;

    // AHB transfer type encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // AHB burst encoding, codes not listed here behave as SINGLE
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        WRAP4  = 3'b010,
        INCR4  = 3'b011
    } hburst_t;

    // Address-phase request from the master
    typedef struct packed {
        logic [ADDR_W-1:0] haddr;
        logic              hwrite;
        htrans_t           htrans;
        hburst_t           hburst;
    } ahb_req_t;

    // Data-phase control seen by the memory and the wait-state logic
    typedef struct packed {
        logic              active;
        logic              write;
        logic [MEM_AW-1:0] word_addr;
    } dphase_t;

endpackage

/* verilog/burst_addr_gen.sv */
`timescale 1ns/10ps

module burst_addr_gen (
    input  logic              clk,
    input  logic              rstn,
    input  ahb_pkg::ahb_req_t req,
    input  logic              hready,
    output ahb_pkg::dphase_t  dphase
);
    import ahb_pkg::*;

    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] base_nxt;
    logic [ADDR_W-1:0] nonseq_base;
    logic [ADDR_W-1:0] byte_addr;
    logic [3:0]        offset;
    logic [3:0]        offset_nxt;
    logic [4:0]        incr_sum;
    logic [2:0]        beat_cnt;
    logic [2:0]        beat_cnt_nxt;
    logic              seq_ok;
    hburst_t           burst;
    hburst_t           burst_nxt;
    logic              write;
    logic              write_nxt;
    logic              active;
    logic              active_nxt;

    // Number of beats in a burst
    function automatic logic [2:0] burst_len(hburst_t b);
        case (b)
            INCR4, WRAP4: burst_len = 3'(BEATS4);
            default:      burst_len = 3'd1;
        endcase
    endfunction

    assign nonseq_base = req.haddr & WRAP4_MASK;
    assign incr_sum    = {1'b0, offset} + 5'd4;

    // SEQ only continues a burst that still has beats left
    assign seq_ok = (beat_cnt != 3'd0) && (beat_cnt < burst_len(burst));

    always_comb begin
        base_nxt     = base;
        offset_nxt   = offset;
        beat_cnt_nxt = beat_cnt;
        burst_nxt    = burst;
        write_nxt    = write;
        active_nxt   = active;
        if (hready) begin
            // IDLE, BUSY and a SEQ past the last beat all close the burst
            base_nxt     = '0;
            offset_nxt   = '0;
            beat_cnt_nxt = '0;
            burst_nxt    = SINGLE;
            write_nxt    = 1'b0;
            active_nxt   = 1'b0;
            if (req.htrans == NONSEQ) begin
                base_nxt     = nonseq_base;
                offset_nxt   = 4'(req.haddr - nonseq_base);
                beat_cnt_nxt = 3'd1;
                burst_nxt    = req.hburst;
                write_nxt    = req.hwrite;
                active_nxt   = 1'b1;
            end else if (req.htrans == SEQ && seq_ok) begin
                base_nxt     = base;
                offset_nxt   = incr_sum[3:0];
                beat_cnt_nxt = beat_cnt + 3'd1;
                burst_nxt    = burst;
                write_nxt    = req.hwrite;
                active_nxt   = 1'b1;
                // INCR4 crosses into the next 16-byte block
                if (burst == INCR4 && incr_sum[4]) begin
                    base_nxt = base + 32'h10;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            base     <= '0;
            offset   <= '0;
            beat_cnt <= '0;
            burst    <= SINGLE;
            write    <= 1'b0;
            active   <= 1'b0;
        end else begin
            base     <= base_nxt;
            offset   <= offset_nxt;
            beat_cnt <= beat_cnt_nxt;
            burst    <= burst_nxt;
            write    <= write_nxt;
            active   <= active_nxt;
        end
    end

    assign byte_addr = base + {{(ADDR_W-4){1'b0}}, offset};

    assign dphase = '{
        active:    active,
        write:     write,
        word_addr: byte_addr[MEM_AW+1:2]
    };

endmodule

/* verilog/wait_state_ctrl.sv */
`timescale 1ns/10ps

module wait_state_ctrl #(
    parameter int WAIT_STATES = 1
) (
    input  logic             clk,
    input  logic             rstn,
    input  ahb_pkg::dphase_t dphase,
    output logic             hready
);

    typedef enum logic {
        READY,
        WAIT
    } ws_state_t;

    ws_state_t state;
    logic [2:0] cnt;

    // Every edge with hready high starts a new data phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= READY;
            cnt   <= '0;
        end else if (hready) begin
            cnt <= 3'(WAIT_STATES);
            if (WAIT_STATES != 0) begin
                state <= WAIT;
            end else begin
                state <= READY;
            end
        end else begin
            case (state)
                WAIT: begin
                    cnt <= cnt - 3'd1;
                    // Last low cycle, release on the next one
                    if (cnt == 3'd1) begin
                        state <= READY;
                    end
                end
                default: begin
                    state <= READY;
                end
            endcase
        end
    end

    // No stall when no transfer is in its data phase
    assign hready = !(state == WAIT && cnt != 3'd0 && dphase.active);

endmodule

/* verilog/ahb_sram.sv */
`timescale 1ns/10ps

module ahb_sram (
    input  logic                       clk,
    input  logic                       rstn,
    input  ahb_pkg::dphase_t           dphase,
    input  logic                       hready,
    input  logic [ahb_pkg::DATA_W-1:0] hwdata,
    output logic [ahb_pkg::DATA_W-1:0] hrdata
);
    import ahb_pkg::*;

    localparam int DEPTH = 2 ** MEM_AW;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DEPTH-1:0]  vld;
    logic              wr_en;
    logic              rd_en;

    // Write completes on the edge that ends the data phase
    assign wr_en = dphase.active && dphase.write && hready;
    assign rd_en = dphase.active && !dphase.write;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[dphase.word_addr] <= hwdata;
        end
    end

    // Words not written since reset read back as zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld <= '0;
        end else if (wr_en) begin
            vld[dphase.word_addr] <= 1'b1;
        end
    end

    always_comb begin
        hrdata = '0;
        if (rd_en && vld[dphase.word_addr]) begin
            hrdata = mem[dphase.word_addr];
        end
    end

endmodule

/* verilog/ahb_mem_slave.sv */
`timescale 1ns/10ps

module ahb_mem_slave #(
    parameter int WAIT_STATES = 1
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  ahb_pkg::ahb_req_t          req,
    input  logic [ahb_pkg::DATA_W-1:0] hwdata,
    output logic [ahb_pkg::DATA_W-1:0] hrdata,
    output logic                       hready
);
    import ahb_pkg::*;

    dphase_t dphase;

    // Beat address and data-phase flags
    burst_addr_gen u_addr_gen (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .hready (hready),
        .dphase (dphase)
    );

    // hready is both driven here and fed back to every block
    wait_state_ctrl #(
        .WAIT_STATES (WAIT_STATES)
    ) u_wait_ctrl (
        .clk    (clk),
        .rstn   (rstn),
        .dphase (dphase),
        .hready (hready)
    );

    ahb_sram u_sram (
        .clk    (clk),
        .rstn   (rstn),
        .dphase (dphase),
        .hready (hready),
        .hwdata (hwdata),
        .hrdata (hrdata)
    );

endmodule

/* tests/ahb_mem_slave_assert.sv */
`timescale 1ns/10ps

module ahb_mem_slave_assert #(
    parameter int WAIT_STATES = 1
) (
    input logic              clk,
    input logic              rstn,
    input ahb_pkg::ahb_req_t req,
    input logic              hready,
    input ahb_pkg::dphase_t  dphase
);
    import ahb_pkg::*;

    logic        bad_reset   = 1'b0;
    logic        bad_release = 1'b0;
    logic        bad_hold    = 1'b0;
    logic        bad_idle    = 1'b0;
    logic        failed;
    int unsigned low_run;

    assign failed = bad_reset | bad_release | bad_hold | bad_idle;

    // Length of the current run of low hready cycles
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            low_run <= 0;
        end else if (!hready) begin
            low_run <= low_run + 1;
        end else begin
            low_run <= 0;
        end
    end

    a_ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> hready)
        else begin
            $error("hready low right after reset");
            bad_reset = 1'b1;
        end

    a_release: assert property (@(posedge clk) disable iff (!rstn)
        !hready |-> low_run < WAIT_STATES)
        else begin
            $error("hready low for more than %0d cycles", WAIT_STATES);
            bad_release = 1'b1;
        end

    a_req_hold: assert property (@(posedge clk) disable iff (!rstn) !hready |=> $stable(req))
        else begin
            $error("request changed while hready low");
            bad_hold = 1'b1;
        end

    a_idle_ends: assert property (@(posedge clk) disable iff (!rstn)
        (hready && req.htrans == IDLE) |=> !dphase.active)
        else begin
            $error("data phase still active after an accepted IDLE");
            bad_idle = 1'b1;
        end

endmodule

bind ahb_mem_slave ahb_mem_slave_assert #(
    .WAIT_STATES (WAIT_STATES)
) u_assert (
    .clk    (clk),
    .rstn   (rstn),
    .req    (req),
    .hready (hready),
    .dphase (dphase)
);

/* tests/tb_ahb_mem_slave.sv */
`timescale 1ns/10ps

module tb_ahb_mem_slave;
    import ahb_pkg::*;

    localparam int WAIT_STATES = 2;
    localparam int WAIT_LIMIT  = 20;
    localparam int N_BURSTS    = 300;

    logic              clk;
    logic              rstn;
    ahb_req_t          req;
    logic [DATA_W-1:0] hwdata;
    logic [DATA_W-1:0] hrdata;
    logic              hready;

    logic [31:0] lfsr;
    logic [31:0] model [64];

    // Request on the bus, with its word and the data for its data phase
    ahb_req_t    cur;
    logic [5:0]  cur_word;
    logic [31:0] cur_wdata;

    // Data phase in progress
    logic        pend_act;
    logic        pend_wr;
    logic [5:0]  pend_word;
    logic [31:0] pend_data;

    ahb_mem_slave #(
        .WAIT_STATES (WAIT_STATES)
    ) uut (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Stop at the first bus rule violation
    always @(posedge clk) begin
        if (uut.u_assert.failed) begin
            $display("error at %0t: a bus rule assertion fired", $time);
            $display("sim failed");
            $fatal(1);
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Finish the current data phase, then put nxt on the bus
    task automatic bus_cycle(input ahb_req_t nxt, input logic [5:0] nxt_word,
                             input logic [31:0] nxt_wdata);
        int lows;
        lows = 0;
        @(negedge clk);
        while (!hready && lows < WAIT_LIMIT) begin
            lows++;
            @(negedge clk);
        end
        if (!hready) begin
            $display("error at %0t: hready stuck low", $time);
            $display("sim failed");
            $fatal(1);
        end
        if (pend_act) begin
            check("wait states", lows, WAIT_STATES);
            if (pend_wr) begin
                model[pend_word] = pend_data;
            end else begin
                check("hrdata", hrdata, model[pend_word]);
            end
        end else begin
            check("wait states", lows, 0);
        end
        pend_act  = (cur.htrans == NONSEQ) || (cur.htrans == SEQ);
        pend_wr   = cur.hwrite;
        pend_word = cur_word;
        pend_data = cur_wdata;
        @(posedge clk);
        req       <= nxt;
        hwdata    <= cur_wdata;
        cur       = nxt;
        cur_word  = nxt_word;
        cur_wdata = nxt_wdata;
    endtask

    task automatic idle_cycles(input int n);
        ahb_req_t r;
        for (int i = 0; i < n; i++) begin
            r.haddr  = rand_bits(32);
            r.hwrite = 1'(rand_bits(1));
            r.htrans = IDLE;
            r.hburst = SINGLE;
            bus_cycle(r, 6'd0, 32'd0);
        end
    endtask

    task automatic run_burst(input hburst_t kind, input logic wr, input logic [31:0] start,
                             input int beats, input int gap);
        ahb_req_t    r;
        logic [31:0] addr;
        for (int i = 0; i < beats; i++) begin
            if (kind == INCR4) begin
                addr = start + 32'(4 * i);
            end else if (kind == WRAP4) begin
                // Stays inside the 16-byte block of the start address
                addr = (start & ~32'hF) | ((start + 32'(4 * i)) & 32'hF);
            end else begin
                addr = start;
            end
            // SEQ beats carry junk on haddr
            r.haddr  = (i == 0) ? start : rand_bits(32);
            r.hwrite = wr;
            r.htrans = (i == 0) ? NONSEQ : SEQ;
            r.hburst = kind;
            bus_cycle(r, addr[7:2], rand_bits(32));
        end
        idle_cycles(gap);
    endtask

    task automatic random_burst();
        logic [1:0]  sel;
        hburst_t     kind;
        logic        wr;
        logic [31:0] start;
        int          beats;
        int          gap;
        sel   = 2'(rand_bits(2));
        kind  = (sel == 2'd1) ? INCR4 : (sel[1] ? WRAP4 : SINGLE);
        wr    = 1'(rand_bits(1));
        start = rand_bits(32) & ~32'h3;
        beats = (kind == SINGLE) ? 1 : BEATS4;
        // Cut short by the next NONSEQ or an IDLE
        if (beats == BEATS4 && rand_bits(2) == 0) begin
            beats = 1 + int'(rand_bits(1)) + int'(rand_bits(1));
        end
        gap = int'(rand_bits(2));
        run_burst(kind, wr, start, beats, gap);
    endtask

    initial begin
        lfsr      = 32'h02eb_e0ec;
        rstn      = 1'b0;
        req       = '{haddr: '0, hwrite: 1'b0, htrans: IDLE, hburst: SINGLE};
        hwdata    = '0;
        cur       = req;
        cur_word  = '0;
        cur_wdata = '0;
        pend_act  = 1'b0;
        pend_wr   = 1'b0;
        pend_word = '0;
        pend_data = '0;
        for (int i = 0; i < 64; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        @(negedge clk);
        check("hready", hready, 1'b1);
        check("hrdata", hrdata, '0);

        // Same word reached through different upper address bits
        run_burst(SINGLE, 1'b1, 32'h1234_5608, 1, 0);
        run_burst(SINGLE, 1'b1, 32'hABCD_01F0, 1, 1);
        run_burst(SINGLE, 1'b1, 32'h0000_0108, 1, 0);
        run_burst(SINGLE, 1'b0, 32'h0000_0008, 1, 0);
        run_burst(SINGLE, 1'b0, 32'h0000_00F0, 1, 1);

        run_burst(INCR4, 1'b1, 32'h0000_0038, 4, 0);
        run_burst(INCR4, 1'b0, 32'h0000_0038, 4, 1);
        run_burst(WRAP4, 1'b1, 32'h0000_0068, 4, 0);
        run_burst(WRAP4, 1'b0, 32'h0000_0064, 4, 2);

        for (int n = 0; n < N_BURSTS; n++) begin
            random_burst();
        end

        // Full readback of the memory
        for (int a = 0; a < 256; a += 16) begin
            run_burst(INCR4, 1'b0, 32'(a), 4, 0);
        end
        idle_cycles(3);

        if (uut.u_assert.failed) begin
            $display("error at %0t: a bus rule assertion fired", $time);
            $display("sim failed");
            $fatal(1);
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* all.f */
verilog/ahb_pkg.sv
verilog/burst_addr_gen.sv
verilog/wait_state_ctrl.sv
verilog/ahb_sram.sv
verilog/ahb_mem_slave.sv
tests/ahb_mem_slave_assert.sv
tests/tb_ahb_mem_slave.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ahb_mem_slave
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the testbench printed its pass line
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^sim passed$$'

clean:
	rm -rf $(BUILD_DIR)
